//--- bldc_driver_top.sv
`timescale 1ns/1ps

module bldc_driver_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             en,
    input  bldc_pkg::hall_t  hall,
    input  bldc_pkg::duty_t  duty_cmd,
    input  logic             direction,
    output bldc_pkg::phase_t phase_h,
    output bldc_pkg::phase_t phase_l,
    output logic             connected,
    output logic             fault
);

    import bldc_pkg::*;

    hall_t  hall_s;
    logic   wiring_fault;
    logic   disconnected;
    logic   clear_wiring;
    logic   drive_en;
    duty_t  duty_applied;
    phase_t drive_high;
    phase_t drive_float;

    // Sensor synchronizer and fault detection
    hall_monitor u_hall_monitor (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .hall         (hall),
        .clear_wiring (clear_wiring),
        .hall_s       (hall_s),
        .wiring_fault (wiring_fault),
        .disconnected (disconnected)
    );

    // Startup ramp, run control and fault handling
    motor_state_ctrl u_motor_state_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .en           (en),
        .duty_cmd     (duty_cmd),
        .hall_s       (hall_s),
        .wiring_fault (wiring_fault),
        .disconnected (disconnected),
        .duty_applied (duty_applied),
        .drive_en     (drive_en),
        .fault        (fault),
        .clear_wiring (clear_wiring),
        .connected    (connected)
    );

    commutation_decoder u_commutation_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .hall_s      (hall_s),
        .direction   (direction),
        .drive_high  (drive_high),
        .drive_float (drive_float)
    );

    // ======================================================================
    // Phase drivers
    // ======================================================================

    // The sourcing phase gets the applied duty, the sinking phase gets zero
    // and so keeps its low side on for most of the period
    for (genvar i = 0; i < 3; i++) begin : g_phase
        duty_t phase_duty;
        logic  phase_float;

        assign phase_duty  = drive_high[i] ? duty_applied : '0;
        assign phase_float = drive_float[i] | ~drive_en;

        phase_pwm u_phase_pwm (
            .clk         (clk),
            .rst_n       (rst_n),
            .duty        (phase_duty),
            .float_phase (phase_float),
            .pwm_h       (phase_h[i]),
            .pwm_l       (phase_l[i])
        );
    end

endmodule

//--- bldc_macros.svh
`ifndef BLDC_MACROS_SVH
`define BLDC_MACROS_SVH

// ==========================================================================
// PWM timing
// ==========================================================================

// Width of every duty-cycle value in the design
`define BLDC_DUTY_W 8

// One PWM period in clock cycles, the phase counter runs 0 to period-1
`define BLDC_PWM_PERIOD 256

// Gap in cycles between one gate switching off and its partner switching on
`define BLDC_DEAD_TIME 4

// Below or at this duty the motor is not driven at all
`define BLDC_MIN_DUTY 8

// ==========================================================================
// Startup ramp and hall checking
// ==========================================================================

// Clock cycles spent on each ramp step
`define BLDC_STARTUP_TICK 256

// Ramp steps taken before the motor is considered started
`define BLDC_STARTUP_STEPS 16

// Hall inputs are checked for fault patterns once every this many cycles
`define BLDC_HALL_SAMPLE_DIV 16

// Consecutive equal samples needed to confirm a fault or a recovery
`define BLDC_HALL_STEADY 8

`endif

//--- bldc_pkg.sv
package bldc_pkg;

    `include "bldc_macros.svh"

    // Duty cycle as applied to the phase PWM compare
    typedef logic [`BLDC_DUTY_W-1:0] duty_t;

    // Raw or synchronized hall sensor code, phase A sits in bit 0
    typedef logic [2:0] hall_t;

    // One bit per motor phase, phase A sits in bit 0
    typedef logic [2:0] phase_t;

    // Motor control states
    // Poll_hall waits for a sensor to come back, err holds a wiring fault
    typedef enum logic [2:0] {
        ST_STOP,
        ST_STARTUP,
        ST_RUN,
        ST_POLL_HALL,
        ST_ERR
    } motor_state_t;

endpackage

//--- commutation_decoder.sv
`timescale 1ns/1ps

module commutation_decoder (
    input  logic             clk,
    input  logic             rst_n,
    input  bldc_pkg::hall_t  hall_s,
    input  logic             direction,
    output bldc_pkg::phase_t drive_high,
    output bldc_pkg::phase_t drive_float
);

    import bldc_pkg::*;

    localparam phase_t PH_A = 3'b001;
    localparam phase_t PH_B = 3'b010;
    localparam phase_t PH_C = 3'b100;

    logic [2:0] step;
    phase_t     fwd_high;
    phase_t     fwd_low;
    phase_t     high_c;
    phase_t     low_c;

    // Hall code to commutation step where 7 marks a code that cannot occur
    always_comb begin
        case (hall_s)
            3'b001:  step = 3'd0;
            3'b011:  step = 3'd1;
            3'b010:  step = 3'd2;
            3'b110:  step = 3'd3;
            3'b100:  step = 3'd4;
            3'b101:  step = 3'd5;
            default: step = 3'd7;
        endcase
    end

    // Forward six-step table in which the third phase floats
    always_comb begin
        case (step)
            3'd0, 3'd1: fwd_high = PH_A;
            3'd2, 3'd3: fwd_high = PH_B;
            3'd4, 3'd5: fwd_high = PH_C;
            default:    fwd_high = '0;
        endcase
        case (step)
            3'd3, 3'd4: fwd_low = PH_A;
            3'd0, 3'd5: fwd_low = PH_B;
            3'd1, 3'd2: fwd_low = PH_C;
            default:    fwd_low = '0;
        endcase
    end

    // Reverse rotation swaps the sourcing and sinking phases
    assign high_c = direction ? fwd_low  : fwd_high;
    assign low_c  = direction ? fwd_high : fwd_low;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            drive_high  <= '0;
            drive_float <= '1;
        end else begin
            drive_high  <= high_c;
            drive_float <= ~(high_c | low_c);
        end
    end

    // A valid code sources exactly one phase and floats exactly one other
    a_high_not_float: assert property (
        @(posedge clk) disable iff (!rst_n)
        (step != 3'd7) |=> $onehot(drive_high) && $onehot(drive_float) &&
                           ((drive_high & drive_float) == '0)
    );

endmodule

//--- hall_monitor.sv
`timescale 1ns/1ps

`include "bldc_macros.svh"

module hall_monitor (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  bldc_pkg::hall_t hall,
    input  logic            clear_wiring,
    output bldc_pkg::hall_t hall_s,
    output logic            wiring_fault,
    output logic            disconnected
);

    import bldc_pkg::*;

    localparam int DIV_W    = $clog2(`BLDC_HALL_SAMPLE_DIV);
    localparam int STEADY_W = $clog2(`BLDC_HALL_STEADY + 1);

    hall_t               hall_meta;
    logic [DIV_W-1:0]    div_cnt;
    logic                sample;
    logic [STEADY_W-1:0] low_cnt;
    logic [STEADY_W-1:0] high_cnt;
    logic [STEADY_W-1:0] valid_cnt;

    // ======================================================================
    // Input synchronizer and sample strobe
    // ======================================================================

    // The hall lines come straight from the motor and pass two flops before any use
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hall_meta <= '0;
            hall_s    <= '0;
        end else begin
            hall_meta <= hall;
            hall_s    <= hall_meta;
        end
    end

    // Fault checking runs on a slow strobe so short glitches are ignored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (!en || sample) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign sample = (div_cnt == DIV_W'(`BLDC_HALL_SAMPLE_DIV - 1));

    // ======================================================================
    // Steady-pattern counters and latched flags
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            low_cnt      <= '0;
            high_cnt     <= '0;
            valid_cnt    <= '0;
            wiring_fault <= 1'b0;
            disconnected <= 1'b0;
        end else if (!en) begin
            // Toggling enable also releases a latched wiring fault
            low_cnt      <= '0;
            high_cnt     <= '0;
            valid_cnt    <= '0;
            wiring_fault <= 1'b0;
        end else begin
            if (sample) begin
                if (hall_s == 3'b000) begin
                    // All lines low points at a short or a broken pull-up
                    high_cnt  <= '0;
                    valid_cnt <= '0;
                    if (low_cnt < STEADY_W'(`BLDC_HALL_STEADY)) begin
                        low_cnt <= low_cnt + 1'b1;
                    end
                    if (low_cnt == STEADY_W'(`BLDC_HALL_STEADY - 1)) begin
                        wiring_fault <= 1'b1;
                    end
                end else if (hall_s == 3'b111) begin
                    // All lines pulled high means the sensor plug is out
                    low_cnt   <= '0;
                    valid_cnt <= '0;
                    if (high_cnt < STEADY_W'(`BLDC_HALL_STEADY)) begin
                        high_cnt <= high_cnt + 1'b1;
                    end
                    if (high_cnt == STEADY_W'(`BLDC_HALL_STEADY - 1)) begin
                        disconnected <= 1'b1;
                    end
                end else begin
                    low_cnt  <= '0;
                    high_cnt <= '0;
                    // Only an unbroken run of valid codes counts as a reconnect
                    if (disconnected) begin
                        if (valid_cnt == STEADY_W'(`BLDC_HALL_STEADY - 1)) begin
                            disconnected <= 1'b0;
                            valid_cnt    <= '0;
                        end else begin
                            valid_cnt <= valid_cnt + 1'b1;
                        end
                    end
                end
            end

            // Unplugging the sensor is the way out of a wiring fault
            // The unplugged state is then tracked as a disconnect
            if (clear_wiring && hall_s == 3'b111) begin
                wiring_fault <= 1'b0;
                disconnected <= 1'b1;
                low_cnt      <= '0;
            end
        end
    end

endmodule

//--- list.f
+incdir+.
bldc_pkg.sv
hall_monitor.sv
motor_state_ctrl.sv
commutation_decoder.sv
phase_pwm.sv
bldc_driver_top.sv
tb_bldc_driver.sv

//--- motor_state_ctrl.sv
`timescale 1ns/1ps

`include "bldc_macros.svh"

module motor_state_ctrl (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            en,
    input  bldc_pkg::duty_t duty_cmd,
    input  bldc_pkg::hall_t hall_s,
    input  logic            wiring_fault,
    input  logic            disconnected,
    output bldc_pkg::duty_t duty_applied,
    output logic            drive_en,
    output logic            fault,
    output logic            clear_wiring,
    output logic            connected
);

    import bldc_pkg::*;

    localparam int    TICK_W   = $clog2(`BLDC_STARTUP_TICK);
    localparam int    STEP_W   = $clog2(`BLDC_STARTUP_STEPS + 1);
    localparam duty_t MIN_DUTY = duty_t'(`BLDC_MIN_DUTY);

    motor_state_t      state;
    logic [TICK_W-1:0] tick_cnt;
    logic [STEP_W-1:0] step_cnt;
    logic              ramp_done;

    // Gates may only switch while the motor is starting or running
    assign drive_en = (state == ST_STARTUP) || (state == ST_RUN);

    // Unplugging the sensor while in err is the request to clear the fault
    assign clear_wiring = en && (state == ST_ERR) && (hall_s == 3'b111);

    // Fixed-time ramp, cut short once the commanded duty is reached
    assign ramp_done = (step_cnt == STEP_W'(`BLDC_STARTUP_STEPS)) ||
                       (duty_applied >= duty_cmd);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            connected <= 1'b1;
        end else begin
            connected <= ~disconnected;
        end
    end

    // ======================================================================
    // Motor state machine
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_STOP;
            duty_applied <= '0;
            fault        <= 1'b0;
            tick_cnt     <= '0;
            step_cnt     <= '0;
        end else if (!en) begin
            state        <= ST_STOP;
            duty_applied <= '0;
            fault        <= 1'b0;
        end else if (wiring_fault && state != ST_ERR) begin
            // A wiring fault overrides every other state
            state        <= ST_ERR;
            duty_applied <= '0;
            fault        <= 1'b1;
        end else if (disconnected && state != ST_POLL_HALL && state != ST_ERR) begin
            state        <= ST_POLL_HALL;
            duty_applied <= '0;
        end else begin
            case (state)
                ST_STOP: begin
                    duty_applied <= '0;
                    tick_cnt     <= '0;
                    step_cnt     <= '0;
                    // Ramp always starts from the lowest duty that turns the rotor
                    if (duty_cmd > MIN_DUTY) begin
                        state        <= ST_STARTUP;
                        duty_applied <= MIN_DUTY;
                    end
                end
                ST_STARTUP: begin
                    if (duty_cmd <= MIN_DUTY) begin
                        state        <= ST_STOP;
                        duty_applied <= '0;
                    end else if (ramp_done) begin
                        state        <= ST_RUN;
                        duty_applied <= duty_cmd;
                    end else if (tick_cnt == TICK_W'(`BLDC_STARTUP_TICK - 1)) begin
                        tick_cnt     <= '0;
                        step_cnt     <= step_cnt + 1'b1;
                        duty_applied <= duty_applied + 1'b1;
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                ST_RUN: begin
                    if (duty_cmd <= MIN_DUTY) begin
                        state        <= ST_STOP;
                        duty_applied <= '0;
                    end else begin
                        duty_applied <= duty_cmd;
                    end
                end
                ST_POLL_HALL: begin
                    // Wait here until the monitor sees a steady valid sensor
                    duty_applied <= '0;
                    if (!disconnected) begin
                        state <= ST_STOP;
                    end
                end
                ST_ERR: begin
                    duty_applied <= '0;
                    if (hall_s == 3'b111) begin
                        state <= ST_POLL_HALL;
                        fault <= 1'b0;
                    end else begin
                        fault <= 1'b1;
                    end
                end
                default: begin
                    state        <= ST_STOP;
                    duty_applied <= '0;
                end
            endcase
        end
    end

    // A reported fault must never coincide with an enabled bridge
    a_fault_no_drive: assert property (
        @(posedge clk) disable iff (!rst_n) fault |-> !drive_en
    );

endmodule

//--- phase_pwm.sv
`timescale 1ns/1ps

`include "bldc_macros.svh"

module phase_pwm (
    input  logic            clk,
    input  logic            rst_n,
    input  bldc_pkg::duty_t duty,
    input  logic            float_phase,
    output logic            pwm_h,
    output logic            pwm_l
);

    localparam int CNT_W = $clog2(`BLDC_PWM_PERIOD);
    localparam int EXT_W = CNT_W + 1;

    logic [CNT_W-1:0] cnt;
    logic [EXT_W-1:0] cnt_ext;
    logic [EXT_W-1:0] duty_ext;
    logic [EXT_W-1:0] l_start;
    logic             h_on;
    logic             l_on;

    // Free-running period counter, shared reset keeps all phases aligned
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt == CNT_W'(`BLDC_PWM_PERIOD - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // One extra bit so duty plus dead time cannot wrap
    assign cnt_ext  = EXT_W'(cnt);
    assign duty_ext = EXT_W'(duty);
    assign l_start  = duty_ext + EXT_W'(`BLDC_DEAD_TIME);

    // High side waits one dead time after the period start
    assign h_on = !float_phase &&
                  (cnt >= CNT_W'(`BLDC_DEAD_TIME)) &&
                  (cnt_ext < duty_ext);

    // Low side waits one dead time after the high side drops
    assign l_on = !float_phase && (cnt_ext >= l_start);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_h <= 1'b0;
            pwm_l <= 1'b0;
        end else begin
            pwm_h <= h_on;
            pwm_l <= l_on;
        end
    end

    // Shoot-through guard on the half bridge
    a_no_shoot_through: assert property (
        @(posedge clk) disable iff (!rst_n) !(pwm_h && pwm_l)
    );

endmodule

//--- tb_bldc_driver.sv
`timescale 1ns/1ps

module tb_bldc_driver;

    import bldc_pkg::*;

    localparam int     NROWS     = 12;
    localparam int     PERIOD    = 256;
    localparam int     DEAD      = 4;
    localparam int     MIN_DUTY  = 8;
    localparam int     RAMP_STEP = 16;
    localparam int     RAMP_DUTY = 200;
    localparam phase_t PA        = 3'b001;
    localparam phase_t PB        = 3'b010;
    localparam phase_t PC        = 3'b100;

    logic   clk;
    logic   rst_n;
    logic   en;
    logic   direction;
    hall_t  hall;
    duty_t  duty_cmd;
    phase_t phase_h;
    phase_t phase_l;
    logic   connected;
    logic   fault;

    // On-cycle counts of the last measured window with one entry per phase
    int h_cnt[3];
    int l_cnt[3];

    int unsigned lcg_state = 32'h6334d082;

    // Stimulus and expected phase roles with one entry per row
    hall_t  t_hall[NROWS];
    logic   t_dir[NROWS];
    duty_t  t_duty[NROWS];
    phase_t t_high[NROWS];
    phase_t t_low[NROWS];
    phase_t t_flt[NROWS];
    logic   t_fault[NROWS];
    logic   t_conn[NROWS];
    int     nrows = 0;

    bldc_driver_top DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (en),
        .hall      (hall),
        .duty_cmd  (duty_cmd),
        .direction (direction),
        .phase_h   (phase_h),
        .phase_l   (phase_l),
        .connected (connected),
        .fault     (fault)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ======================================================================
    // Reporting, random numbers and the stimulus table
    // ======================================================================

    task automatic fail_stop();
        $display("sim failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check(input int actual, input int expected, input string what);
        if (actual != expected) begin
            $display("error at time %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            fail_stop();
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout while waiting for %s", what);
        fail_stop();
    endtask

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Valid run duty that is always above the minimum
    function duty_t rand_duty();
        lcg_state = lcg_next(lcg_state);
        return duty_t'(MIN_DUTY + 1 + (lcg_state >> 16) % 240);
    endfunction

    task automatic add_row(input hall_t h, input logic dir, input duty_t duty,
                           input phase_t hi, input phase_t lo, input phase_t fl);
        t_hall[nrows]  = h;
        t_dir[nrows]   = dir;
        t_duty[nrows]  = duty;
        t_high[nrows]  = hi;
        t_low[nrows]   = lo;
        t_flt[nrows]   = fl;
        t_fault[nrows] = 1'b0;
        t_conn[nrows]  = 1'b1;
        nrows++;
    endtask

    // Forward six-step sequence first and then reverse with high and low swapped
    task automatic fill_table();
        add_row(3'b001, 1'b0, 128,         PA, PB, PC);
        add_row(3'b011, 1'b0, 60,          PA, PC, PB);
        add_row(3'b010, 1'b0, 200,         PB, PC, PA);
        add_row(3'b110, 1'b0, rand_duty(), PB, PA, PC);
        add_row(3'b100, 1'b0, rand_duty(), PC, PA, PB);
        add_row(3'b101, 1'b0, 16,          PC, PB, PA);
        add_row(3'b001, 1'b1, rand_duty(), PB, PA, PC);
        add_row(3'b011, 1'b1, 240,         PC, PA, PB);
        add_row(3'b010, 1'b1, 9,           PC, PB, PA);
        add_row(3'b110, 1'b1, rand_duty(), PA, PB, PC);
        add_row(3'b100, 1'b1, 100,         PA, PC, PB);
        add_row(3'b101, 1'b1, rand_duty(), PB, PC, PA);
    endtask

    // ======================================================================
    // Driving and measuring
    // ======================================================================

    task automatic apply(input hall_t h, input logic dir, input duty_t duty);
        @(posedge clk);
        #1;
        hall      = h;
        direction = dir;
        duty_cmd  = duty;
    endtask

    // Counts the gates over one full PWM period, sampled mid-cycle where they are stable
    task automatic measure_window();
        for (int i = 0; i < 3; i++) begin
            h_cnt[i] = 0;
            l_cnt[i] = 0;
        end
        repeat (PERIOD) begin
            @(negedge clk);
            check(int'(phase_h & phase_l), 0, "high and low gates on together");
            for (int i = 0; i < 3; i++) begin
                h_cnt[i] += phase_h[i];
                l_cnt[i] += phase_l[i];
            end
        end
    endtask

    task automatic check_quiet(input string what);
        measure_window();
        for (int i = 0; i < 3; i++) begin
            check(h_cnt[i], 0, $sformatf("%s, high cycles on phase %0d", what, i));
            check(l_cnt[i], 0, $sformatf("%s, low cycles on phase %0d", what, i));
        end
    endtask

    // Sourcing phase loses one dead time at the start and one before its low side
    task automatic check_row_counts(input int r);
        int eh;
        int el;
        for (int i = 0; i < 3; i++) begin
            eh = 0;
            el = 0;
            if (t_high[r][i]) begin
                eh = (t_duty[r] > DEAD) ? t_duty[r] - DEAD : 0;
                el = PERIOD - t_duty[r] - DEAD;
                el = (el > 0) ? el : 0;
            end else if (t_low[r][i]) begin
                el = PERIOD - DEAD;
            end else if (!t_flt[r][i]) begin
                $display("row %0d gives phase %0d no role", r, i);
                fail_stop();
            end
            check(h_cnt[i], eh, $sformatf("row %0d, high cycles on phase %0d", r, i));
            check(l_cnt[i], el, $sformatf("row %0d, low cycles on phase %0d", r, i));
        end
    endtask

    task automatic wait_status(input logic want_fault, input logic want_conn,
                               input int max_cycles, input string what);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < max_cycles && !seen; n++) begin
            @(negedge clk);
            seen = (fault === want_fault) && (connected === want_conn);
        end
        if (!seen) begin
            timeout_fail(what);
        end
    endtask

    // A driven bridge never shows more than one dead time with every gate off
    task automatic wait_gates_off(input int max_cycles, input string what);
        int quiet;
        quiet = 0;
        for (int n = 0; n < max_cycles && quiet < 2 * DEAD; n++) begin
            @(negedge clk);
            quiet = (phase_h == '0 && phase_l == '0) ? quiet + 1 : 0;
        end
        if (quiet < 2 * DEAD) begin
            timeout_fail(what);
        end
    endtask

    task automatic wait_high_count(input int idx, input int target, input int max_windows);
        logic done;
        done = 1'b0;
        for (int n = 0; n < max_windows && !done; n++) begin
            measure_window();
            done = (h_cnt[idx] == target);
        end
        if (!done) begin
            timeout_fail("the motor to reach the run duty");
        end
    endtask

    // Phase A is the sourcing phase for hall 001 forward
    task automatic track_ramp(input int first_limit, input int max_windows);
        int   prev;
        logic done;
        measure_window();
        check(int'(h_cnt[0] <= first_limit), 1, "first ramp window above its limit");
        prev = h_cnt[0];
        done = (prev == RAMP_DUTY - DEAD);
        for (int n = 0; n < max_windows && !done; n++) begin
            measure_window();
            check(int'(h_cnt[0] >= prev), 1, "ramp window count decreased");
            check(int'(h_cnt[0] <= RAMP_DUTY - DEAD), 1, "ramp overshot the command");
            prev = h_cnt[0];
            done = (prev == RAMP_DUTY - DEAD);
        end
        if (!done) begin
            timeout_fail("the startup ramp to reach full duty");
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        rst_n     = 1'b0;
        en        = 1'b0;
        hall      = 3'b001;
        direction = 1'b0;
        duty_cmd  = '0;
        fill_table();
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;

        @(negedge clk);
        check(phase_h, 0, "phase_h after reset");
        check(phase_l, 0, "phase_l after reset");
        check(fault, 0, "fault after reset");
        check(connected, 1, "connected after reset");

        // Disabled controller ignores the duty command
        apply(3'b001, 1'b0, 100);
        check_quiet("enable low");

        // Bring the motor through startup into run on the first row
        apply(t_hall[0], t_dir[0], t_duty[0]);
        en = 1'b1;
        wait_high_count(0, t_duty[0] - DEAD, 24);

        for (int r = 0; r < nrows; r++) begin
            apply(t_hall[r], t_dir[r], t_duty[r]);
            // The hall path is four cycles deep and the duty path two
            repeat (8) @(posedge clk);
            measure_window();
            check_row_counts(r);
            check(fault, t_fault[r], $sformatf("row %0d, fault", r));
            check(connected, t_conn[r], $sformatf("row %0d, connected", r));
        end

        // Duty at the minimum stops the motor
        apply(3'b001, 1'b0, MIN_DUTY);
        wait_gates_off(32, "the gate outputs to switch off");
        check_quiet("stop state");
        check(fault, 0, "fault after stop");
        check(connected, 1, "connected after stop");

        // Ramp from stop up to the commanded duty
        apply(3'b001, 1'b0, RAMP_DUTY);
        track_ramp(RAMP_DUTY - DEAD, 24);

        // Sensor unplugged while running
        apply(3'b111, 1'b0, RAMP_DUTY);
        wait_status(1'b0, 1'b0, 400, "connected to drop");
        check_quiet("sensor disconnected");
        check(fault, 0, "fault during disconnect");
        apply(3'b001, 1'b0, RAMP_DUTY);
        wait_status(1'b0, 1'b1, 400, "connected to return");
        track_ramp(MIN_DUTY + RAMP_STEP - DEAD, 24);

        // All-low hall code latches a wiring fault and unplugging clears it
        apply(3'b000, 1'b0, RAMP_DUTY);
        wait_status(1'b1, 1'b1, 400, "fault to rise");
        check_quiet("wiring fault");
        check(fault, 1, "fault held in err");
        apply(3'b111, 1'b0, RAMP_DUTY);
        wait_status(1'b0, 1'b0, 100, "fault to clear");
        apply(3'b001, 1'b0, RAMP_DUTY);
        wait_status(1'b0, 1'b1, 400, "connected after the wiring fault");

        $display("sim passed");
        $finish;
    end

endmodule
